// File: logic/isaPkg.sv
package isaPkg;

   localparam int wordW    = 16;                // Datapath and instruction width
   localparam int regCount = 8;                 // General purpose registers

   // Opcode sits in bits 15:11 of every word
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,                       // Stop the processor
      opNop   = 5'b00001,
      opJ     = 5'b00100,                       // PC relative jump
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opLbi   = 5'b11000,                       // Load byte immediate
      opAlu   = 5'b11011,                       // Register ALU group selected by funct
      opSeq   = 5'b11100,
      opSlt   = 5'b11101,
      opSle   = 5'b11110
   } opcodeT;

   // Funct codes of the register ALU group
   localparam logic [1:0] functAdd  = 2'b00;
   localparam logic [1:0] functSub  = 2'b01;
   localparam logic [1:0] functXor  = 2'b10;
   localparam logic [1:0] functAndn = 2'b11;

   // Same word seen as register format or immediate format
   typedef union packed {
      struct packed {
         opcodeT     opcode;                    // 15:11
         logic [2:0] rs;                        // 10:8
         logic [2:0] rt;                        // 7:5
         logic [2:0] rd;                        // 4:2
         logic [1:0] funct;                     // 1:0
      } rForm;
      struct packed {
         opcodeT     opcode;                    // 15:11
         logic [2:0] rs;                        // 10:8
         logic [2:0] rd;                        // 7:5
         logic [4:0] imm;                       // 4:0
      } iForm;
   } instrT;

endpackage

// File: logic/ctlPkg.sv
package ctlPkg;

   // ALU function applied to readData1 and operand B
   typedef enum logic [2:0] {
      aluAdd, aluSub, aluXor, aluAndn,
      aluPassB                                  // Result is operand B as is
   } aluOpT;

   // Set on compare, overrides the ALU result
   typedef enum logic [1:0] {condNone, condEq, condLt, condLe} condT;

   // Next PC source
   typedef enum logic [1:0] {brNone, brBeqz, brBnez, brJump} branchT;

   // Destination register field
   typedef enum logic [1:0] {
      destRs,                                   // Bits 10:8
      destRt,                                   // Bits 7:5
      destRd                                    // Bits 4:2
   } regDestT;

   localparam int    romWords    = 256;         // Instruction ROM depth
   localparam int    ramWords    = 256;         // Data RAM depth
   localparam string programFile = "program.hex";

endpackage

// File: logic/ctlIf.sv
`timescale 1ns/10ps

interface ctlIf import ctlPkg::*, isaPkg::*; ();

   logic             regWrite;                  // Register file write request
   regDestT          regDest;
   logic             aluSrc;                    // Operand B is imm when set
   aluOpT            aluOp;
   condT             condOp;
   branchT           branchCode;
   logic             memRead;
   logic             memWrite;
   logic             memToReg;                  // Writeback from RAM instead of ALU
   logic [wordW-1:0] imm;                       // Extended immediate

   modport ctrl (output regWrite, regDest, aluSrc, aluOp, condOp, branchCode,
                 memRead, memWrite, memToReg, imm);
   modport dec  (input regWrite, regDest);
   modport exe  (input aluSrc, aluOp, condOp, branchCode, imm);
   modport mem  (input memRead, memWrite, memToReg);

endinterface

// File: logic/control.sv
`timescale 1ns/10ps

module control import isaPkg::*, ctlPkg::*; (
   input  instrT instr,
   ctlIf.ctrl    ctl,
   output logic  err
);

   logic [wordW-1:0] word;                      // Raw view for the long immediates
   logic [wordW-1:0] sext5, zext5, sext8, sext11;

   assign word   = instr;
   assign sext5  = {{(wordW-5){word[4]}}, word[4:0]};
   assign zext5  = {{(wordW-5){1'b0}}, word[4:0]};
   assign sext8  = {{(wordW-8){word[7]}}, word[7:0]};
   assign sext11 = {{(wordW-11){word[10]}}, word[10:0]};

   always_comb begin
      ctl.regWrite   = 1'b0;                    // Defaults give a NOP
      ctl.regDest    = destRd;
      ctl.aluSrc     = 1'b0;
      ctl.aluOp      = aluAdd;
      ctl.condOp     = condNone;
      ctl.branchCode = brNone;
      ctl.memRead    = 1'b0;
      ctl.memWrite   = 1'b0;
      ctl.memToReg   = 1'b0;
      ctl.imm        = sext5;
      err            = 1'b0;
      case (instr.rForm.opcode)
         opHalt, opNop: ;                       // Nothing written
         opAddi, opSubi, opXori, opAndni: begin
            ctl.regWrite = 1'b1;
            ctl.regDest  = destRt;              // I form rd is in 7:5
            ctl.aluSrc   = 1'b1;
            case (instr.iForm.opcode)
               opAddi:  ctl.aluOp = aluAdd;
               opSubi:  ctl.aluOp = aluSub;
               opXori:  ctl.aluOp = aluXor;
               default: ctl.aluOp = aluAndn;
            endcase
            // Logical immediates are zero extended
            if (instr.iForm.opcode == opXori || instr.iForm.opcode == opAndni) begin
               ctl.imm = zext5;
            end
         end
         opAlu: begin
            ctl.regWrite = 1'b1;
            case (instr.rForm.funct)
               functAdd:  ctl.aluOp = aluAdd;
               functSub:  ctl.aluOp = aluSub;
               functXor:  ctl.aluOp = aluXor;
               functAndn: ctl.aluOp = aluAndn;
               default:   ctl.aluOp = aluAdd;
            endcase
         end
         opSeq, opSlt, opSle: begin
            ctl.regWrite = 1'b1;
            ctl.condOp   = (instr.rForm.opcode == opSeq) ? condEq :
                           (instr.rForm.opcode == opSlt) ? condLt : condLe;
         end
         opLbi: begin
            ctl.regWrite = 1'b1;
            ctl.regDest  = destRs;              // LBI writes the rs field
            ctl.aluSrc   = 1'b1;
            ctl.aluOp    = aluPassB;
            ctl.imm      = sext8;
         end
         opSt: begin
            ctl.memWrite = 1'b1;                // Address is rs plus imm
            ctl.aluSrc   = 1'b1;
         end
         opLd: begin
            ctl.regWrite = 1'b1;
            ctl.regDest  = destRt;
            ctl.aluSrc   = 1'b1;
            ctl.memRead  = 1'b1;
            ctl.memToReg = 1'b1;
         end
         opBeqz, opBnez: begin
            ctl.branchCode = (instr.iForm.opcode == opBeqz) ? brBeqz : brBnez;
            ctl.imm        = sext8;
         end
         opJ: begin
            ctl.branchCode = brJump;
            ctl.imm        = sext11;            // 11 bit displacement
         end
         default: err = 1'b1;                   // Unknown opcode leaves writes off
      endcase
   end

endmodule

// File: logic/fetch.sv
`timescale 1ns/10ps

module fetch import isaPkg::*, ctlPkg::*; (
   input  logic             clk,
   input  logic             rstN,
   input  logic             pcSrc,              // Take target next
   input  logic [wordW-1:0] target,
   input  logic             halt,               // Current word is HALT
   output instrT            instr,
   output logic [wordW-1:0] pc,                 // Byte address of current word
   output logic             halted
);

   localparam int romIdxW = $clog2(romWords);

   logic [wordW-1:0] rom [romWords];            // Program store
   logic [wordW-1:0] pcPlus2;
   logic [wordW-1:0] nextPc;

   initial begin
      $readmemh(programFile, rom);
   end

   assign instr   = rom[pc[romIdxW:1]];         // Word aligned fetch
   assign pcPlus2 = pc + wordW'(2);
   assign nextPc  = pcSrc ? target : pcPlus2;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
      end else if (!(halt || halted)) begin
         pc <= nextPc;                          // Frozen on HALT
      end
   end

   // Sticky until reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         halted <= 1'b0;
      end else if (halt) begin
         halted <= 1'b1;
      end
   end

endmodule

// File: logic/decode.sv
`timescale 1ns/10ps

module decode import isaPkg::*, ctlPkg::*; (
   input  logic                        clk,
   input  logic                        rstN,
   input  instrT                       instr,
   ctlIf.dec                           ctl,
   input  logic                        halted,
   input  logic [wordW-1:0]            wbData,
   output logic [wordW-1:0]            readData1,
   output logic [wordW-1:0]            readData2,
   output logic                        wbValid,
   output logic [$clog2(regCount)-1:0] wbReg
);

   logic [wordW-1:0] regs [regCount];           // Register file

   assign readData1 = regs[instr.rForm.rs];     // Old value this cycle
   assign readData2 = regs[instr.rForm.rt];     // Also the store data

   always_comb begin
      unique case (ctl.regDest)
         destRs:  wbReg = instr.rForm.rs;
         destRt:  wbReg = instr.rForm.rt;
         default: wbReg = instr.rForm.rd;
      endcase
   end

   // No writes once halted or while in reset
   assign wbValid = ctl.regWrite && !halted && rstN;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (wbValid) begin
         regs[wbReg] <= wbData;
      end
   end

endmodule

// File: logic/execute.sv
`timescale 1ns/10ps

module execute import isaPkg::*, ctlPkg::*; (
   ctlIf.exe                ctl,
   input  logic [wordW-1:0] readData1,          // rs value
   input  logic [wordW-1:0] readData2,          // rt value
   input  logic [wordW-1:0] pc,
   output logic [wordW-1:0] aluResult,
   output logic [wordW-1:0] target,
   output logic             pcSrc
);

   logic [wordW-1:0] opB;
   logic [wordW-1:0] aluOut;
   logic             setBit;                    // Compare outcome
   logic             rsZero;

   assign opB = ctl.aluSrc ? ctl.imm : readData2;

   always_comb begin
      unique case (ctl.aluOp)
         aluAdd:   aluOut = readData1 + opB;
         aluSub:   aluOut = readData1 - opB;    // rs minus operand B
         aluXor:   aluOut = readData1 ^ opB;
         aluAndn:  aluOut = readData1 & ~opB;
         aluPassB: aluOut = opB;                // LBI
         default:  aluOut = '0;
      endcase
   end

   // Signed compares always use the two register values
   always_comb begin
      unique case (ctl.condOp)
         condEq:  setBit = (readData1 == readData2);
         condLt:  setBit = ($signed(readData1) < $signed(readData2));
         condLe:  setBit = ($signed(readData1) <= $signed(readData2));
         default: setBit = 1'b0;
      endcase
   end

   assign aluResult = (ctl.condOp != condNone) ? {{(wordW-1){1'b0}}, setBit} : aluOut;

   assign rsZero = (readData1 == '0);
   assign target = pc + wordW'(2) + ctl.imm;    // Relative to next word

   always_comb begin
      unique case (ctl.branchCode)
         brBeqz:  pcSrc = rsZero;
         brBnez:  pcSrc = !rsZero;
         brJump:  pcSrc = 1'b1;
         default: pcSrc = 1'b0;
      endcase
   end

endmodule

// File: logic/memory.sv
`timescale 1ns/10ps

module memory import isaPkg::*, ctlPkg::*; (
   input  logic             clk,
   input  logic             rstN,
   ctlIf.mem                ctl,
   input  logic             halted,
   input  logic [wordW-1:0] aluResult,          // Address or ALU writeback value
   input  logic [wordW-1:0] storeData,
   output logic [wordW-1:0] wbData
);

   localparam int ramIdxW = $clog2(ramWords);

   logic [wordW-1:0]   ram [ramWords];          // Data store
   logic [ramIdxW-1:0] idx;
   logic               memWe;
   logic [wordW-1:0]   rdData;

   // Unwritten words read back as zero
   initial begin
      for (int i = 0; i < ramWords; i++) begin
         ram[i] = '0;
      end
   end

   assign idx   = aluResult[ramIdxW:1];         // Word index from byte address
   assign memWe = ctl.memWrite && !halted && rstN;

   always_ff @(posedge clk) begin
      if (memWe) begin
         ram[idx] <= storeData;
      end
   end

   assign rdData = ctl.memRead ? ram[idx] : '0;
   assign wbData = ctl.memToReg ? rdData : aluResult;   // Writeback select

endmodule

// File: logic/proc.sv
`timescale 1ns/10ps

module proc import isaPkg::*; (
   input  logic             clk,
   input  logic             rstN,
   output logic             err,                // Illegal opcode seen
   output logic             halted,
   output logic             wbValid,            // Register write this cycle
   output logic [2:0]       wbReg,
   output logic [wordW-1:0] wbData,
   output logic [wordW-1:0] pc                  // Address of current word
);

   instrT            instr;                     // Fetch to control and decode
   logic [wordW-1:0] readData1;
   logic [wordW-1:0] readData2;
   logic [wordW-1:0] aluResult;                 // Execute to memory
   logic [wordW-1:0] target;                    // Execute to fetch
   logic             pcSrc;

   ctlIf ctlBus ();                             // Control bundle

   control control0 (
      .instr (instr),
      .ctl   (ctlBus.ctrl),
      .err   (err)
   );

   fetch fetch0 (
      .clk    (clk),
      .rstN   (rstN),
      .pcSrc  (pcSrc),
      .target (target),
      .halt   (instr.rForm.opcode == opHalt),
      .instr  (instr),
      .pc     (pc),
      .halted (halted)
   );

   decode decode0 (
      .clk       (clk),
      .rstN      (rstN),
      .instr     (instr),
      .ctl       (ctlBus.dec),
      .halted    (halted),
      .wbData    (wbData),                      // Loops back from memory
      .readData1 (readData1),
      .readData2 (readData2),
      .wbValid   (wbValid),
      .wbReg     (wbReg)
   );

   execute execute0 (
      .ctl       (ctlBus.exe),
      .readData1 (readData1),
      .readData2 (readData2),
      .pc        (pc),
      .aluResult (aluResult),
      .target    (target),
      .pcSrc     (pcSrc)
   );

   memory memory0 (
      .clk       (clk),
      .rstN      (rstN),
      .ctl       (ctlBus.mem),
      .halted    (halted),
      .aluResult (aluResult),
      .storeData (readData2),
      .wbData    (wbData)
   );

endmodule

// File: test/procTb.sv
`timescale 1ns/10ps

module procTb;

   localparam int resetCycles   = 16;
   localparam int timeoutCycles = 16 + 4 * 30;  // Reset plus four cycles per program word
   localparam int tailCycles    = 8;            // Watched after HALT
   localparam int clsRegAlu     = 0;            // Test index of each written value
   localparam int clsImm        = 1;
   localparam int clsMem        = 2;
   localparam int clsNone       = 3;

   logic        clk;
   logic        rstN;
   logic        err;
   logic        halted;
   logic        wbValid;
   logic [2:0]  wbReg;
   logic [15:0] wbData;
   logic [15:0] pc;

   logic [15:0] progMem [256];                  // Model copy of the program
   logic [15:0] mRegs [8];
   logic [15:0] mRam [256];
   logic [15:0] mPc;
   logic        mHalted;
   logic        checkEn = 1'b0;                 // A predicted cycle is pending

   logic        expWbValid;                     // Prediction for the current cycle
   logic [2:0]  expWbReg;
   logic [15:0] expWbData;
   logic        memWe;
   logic [15:0] memAddr;
   logic [15:0] memData;
   logic [15:0] nextPc;
   logic        halting;
   int          expClass;

   logic [19:0] expWb;
   logic [19:0] actWb;
   logic        wbMatch;
   int          hits [5] = '{default: 0};
   int          fails [5] = '{default: 0};
   string       testName [5];
   int          cycleCnt;
   int          totalHits;
   int          totalFails;
   logic        unreached;

   proc dut_i (
      .clk     (clk),
      .rstN    (rstN),
      .err     (err),
      .halted  (halted),
      .wbValid (wbValid),
      .wbReg   (wbReg),
      .wbData  (wbData),
      .pc      (pc)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;                       // 40 ns period

   // Decode the word at mPc and work out its effects
   task automatic predictStep();
      logic [15:0] w, a, b;
      logic [15:0] imm5s, imm5z, imm8, imm11;
      w          = progMem[mPc[8:1]];
      a          = mRegs[w[10:8]];
      b          = mRegs[w[7:5]];
      imm5s      = {{11{w[4]}}, w[4:0]};
      imm5z      = {11'b0, w[4:0]};
      imm8       = {{8{w[7]}}, w[7:0]};
      imm11      = {{5{w[10]}}, w[10:0]};
      expWbValid = 1'b0;
      expWbReg   = w[7:5];                      // Immediate form and LD destination
      expWbData  = '0;
      memWe      = 1'b0;
      memAddr    = a + imm5s;
      memData    = b;
      nextPc     = mPc + 16'd2;
      halting    = 1'b0;
      expClass   = clsNone;
      if (mHalted) begin
         nextPc = mPc;                          // Frozen on the HALT word
      end else begin
         case (w[15:11])
            5'b00000: begin                     // HALT
               halting = 1'b1;
               nextPc  = mPc;
            end
            5'b11011: begin                     // Register ALU group
               expClass   = clsRegAlu;
               expWbValid = 1'b1;
               expWbReg   = w[4:2];
               case (w[1:0])
                  2'b00:   expWbData = a + b;
                  2'b01:   expWbData = a - b;
                  2'b10:   expWbData = a ^ b;
                  default: expWbData = a & ~b;
               endcase
            end
            5'b01000, 5'b01001, 5'b01010, 5'b01011: begin
               expClass   = clsImm;
               expWbValid = 1'b1;
               case (w[12:11])
                  2'b00:   expWbData = a + imm5s;
                  2'b01:   expWbData = a - imm5s;
                  2'b10:   expWbData = a ^ imm5z;   // Logical forms zero extend
                  default: expWbData = a & ~imm5z;
               endcase
            end
            5'b11100, 5'b11101, 5'b11110: begin // SEQ SLT SLE on signed values
               expClass   = clsImm;
               expWbValid = 1'b1;
               expWbReg   = w[4:2];
               case (w[12:11])
                  2'b00:   expWbData = {15'b0, a == b};
                  2'b01:   expWbData = {15'b0, $signed(a) < $signed(b)};
                  default: expWbData = {15'b0, $signed(a) <= $signed(b)};
               endcase
            end
            5'b11000: begin                     // LBI
               expClass   = clsImm;
               expWbValid = 1'b1;
               expWbReg   = w[10:8];
               expWbData  = imm8;
            end
            5'b10000: begin                     // ST
               expClass = clsMem;
               memWe    = 1'b1;
            end
            5'b10001: begin                     // LD
               expClass   = clsMem;
               expWbValid = 1'b1;
               expWbData  = mRam[memAddr[8:1]];
            end
            5'b01100: nextPc = (a == 16'd0) ? mPc + 16'd2 + imm8 : nextPc;
            5'b01101: nextPc = (a != 16'd0) ? mPc + 16'd2 + imm8 : nextPc;
            5'b00100: nextPc = mPc + 16'd2 + imm11;
            default: ;                          // NOP
         endcase
      end
   endtask

   task automatic commitStep();
      if (expWbValid) begin
         mRegs[expWbReg] = expWbData;
      end
      if (memWe) begin
         mRam[memAddr[8:1]] = memData;
      end
      mHalted = mHalted || halting;
      mPc     = nextPc;
   endtask

   // Model steps between edges so its outputs are stable at each rising edge
   always @(negedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < 8; i++) begin
            mRegs[i] = '0;
         end
         for (int i = 0; i < 256; i++) begin
            mRam[i] = '0;                       // Data RAM starts out zero
         end
         mPc     = '0;
         mHalted = 1'b0;
      end else if (checkEn) begin
         commitStep();                          // Took effect at the last rising edge
      end
      checkEn = rstN;
      predictStep();
   end

   assign expWb   = {expWbValid, expWbReg, expWbData};
   assign actWb   = {wbValid, wbReg, wbData};
   assign wbMatch = (wbValid == expWbValid) &&
                    (!expWbValid || (wbReg == expWbReg && wbData == expWbData));

   regAluChk: assert property (@(posedge clk) (checkEn && expClass == clsRegAlu) |-> wbMatch)
      else begin
         fails[0]++;
         $display("CHECK FAILED %s: expected %h actual %h", testName[0],
                  $sampled(expWb), $sampled(actWb));
      end
   immChk: assert property (@(posedge clk) (checkEn && expClass == clsImm) |-> wbMatch)
      else begin
         fails[1]++;
         $display("CHECK FAILED %s: expected %h actual %h", testName[1],
                  $sampled(expWb), $sampled(actWb));
      end
   memChk: assert property (@(posedge clk) (checkEn && expClass == clsMem) |-> wbMatch)
      else begin
         fails[2]++;
         $display("CHECK FAILED %s: expected %h actual %h", testName[2],
                  $sampled(expWb), $sampled(actWb));
      end
   flowChk: assert property (@(posedge clk) checkEn |-> (pc == mPc && wbValid == expWbValid))
      else begin
         fails[3]++;
         $display("CHECK FAILED %s: expected %h actual %h", testName[3],
                  $sampled({mPc, expWbValid}), $sampled({pc, wbValid}));
      end
   haltChk: assert property (@(posedge clk) checkEn |-> (halted == mHalted && !err))
      else begin
         fails[4]++;
         $display("CHECK FAILED %s: expected %b actual %b", testName[4],
                  $sampled({mHalted, 1'b0}), $sampled({halted, err}));
      end

   always @(posedge clk) begin
      if (checkEn) begin
         if (expClass != clsNone) begin
            hits[expClass]++;
         end
         hits[3]++;                             // Flow and halt run every cycle
         hits[4]++;
      end
   end

   initial begin
      rstN     = 1'b0;
      testName = '{"regAlu", "immOps", "memOps", "flow", "haltErr"};
      $readmemh("program.hex", progMem);
      repeat (resetCycles) @(posedge clk);
      rstN <= 1'b1;
      while (!halted) begin
         @(negedge clk);
      end
      repeat (tailCycles) @(negedge clk);
      totalHits  = 0;
      totalFails = 0;
      unreached  = 1'b0;
      for (int t = 0; t < 5; t++) begin
         $display("%s: %0d checked, %0d wrong", testName[t], hits[t], fails[t]);
         if (hits[t] == 0) begin
            $display("Test %s was never exercised by the program", testName[t]);
            unreached = 1'b1;
         end
         totalHits  += hits[t];
         totalFails += fails[t];
      end
      $display("Totals: %0d checked, %0d wrong", totalHits, totalFails);
      if (totalFails == 0 && !unreached) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   initial begin
      cycleCnt = 0;
      while (cycleCnt < timeoutCycles) begin
         @(posedge clk);
         cycleCnt++;
      end
      $display("Timeout: processor did not halt within %0d cycles", timeoutCycles);
      $display("Checks failed");
      $finish;
   end

endmodule

// File: verilog.f
logic/isaPkg.sv
logic/ctlPkg.sv
logic/ctlIf.sv
logic/control.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/memory.sv
logic/proc.sv
test/procTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module procTb -f verilog.f -o procSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/procSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "All checks passed" sim.log; then
   exit 0
fi
exit 1

// File: program.hex
// One 16-bit instruction word per line in hex, from byte address 0 upward
// After the word: word index and the instruction it encodes
C105 // 00 LBI  r1, 5
C2FD // 01 LBI  r2, -3
D94C // 02 ADD  r3 = r1 + r2
D951 // 03 SUB  r4 = r1 - r2
D956 // 04 XOR  r5 = r1 ^ r2
DA3B // 05 ANDN r6 = r2 & ~r1
41FC // 06 ADDI r7 = r1 + -4
4A03 // 07 SUBI r0 = r2 - 3
549F // 08 XORI r4 = r4 ^ 0x1f
5DBF // 09 ANDNI r5 = r5 & ~0x1f
E138 // 10 SEQ  r6 = r1 == r1
EA3C // 11 SLT  r7 = r2 < r1
F158 // 12 SLE  r6 = r1 <= r2
8324 // 13 ST   mem[r3 + 4] = r1
8B84 // 14 LD   r4 = mem[r3 + 4]
8BA8 // 15 LD   r5 = mem[r3 + 8]
6502 // 16 BEQZ r5, +2 taken
C677 // 17 LBI  r6, 0x77 skipped
6102 // 18 BEQZ r1, +2 not taken
C303 // 19 LBI  r3, 3
4B61 // 20 SUBI r3 = r3 - 1
6BFC // 21 BNEZ r3, -4 back to 20
2002 // 22 J    +2
C755 // 23 LBI  r7, 0x55 skipped
0800 // 24 NOP
DCE0 // 25 ADD  r0 = r4 + r7
0000 // 26 HALT
C766 // 27 LBI  r7, 0x66 never reached
0800 // 28 NOP
0800 // 29 NOP
